/* hw/coeff_lowpass.svh */
`ifndef COEFF_LOWPASS_SVH
`define COEFF_LOWPASS_SVH

// symmetric low-pass table loaded into bank 2
localparam logic [accel_fir_pkg::sample_w-1:0] lowpass_coeffs [accel_fir_pkg::num_taps] = '{
    16'hFFFE,
    16'hFFF6,
    16'hFFDC,
    16'hFF9E,
    16'hFF2A,
    16'hFE82,
    16'hFDCD,
    16'hFD70,
    16'hFE07,
    16'h0044,
    16'h04AE,
    16'h0B4E,
    16'h1380,
    16'h1BF4,
    16'h22F7,
    16'h26F2,   // centre pair
    16'h26F2,
    16'h22F7,
    16'h1BF4,
    16'h1380,
    16'h0B4E,
    16'h04AE,
    16'h0044,
    16'hFE07,
    16'hFD70,
    16'hFDCD,
    16'hFE82,
    16'hFF2A,
    16'hFF9E,
    16'hFFDC,
    16'hFFF6,
    16'hFFFE
};

`endif

/* hw/accel_fir_pkg.sv */
package accel_fir_pkg;

    localparam int sample_w = 16;   // samples and coefficients
    localparam int num_taps = 32;
    localparam int tap_idx_w = 5;
    localparam int num_banks = 4;
    localparam int bank_w = 2;
    localparam int acc_w = 40;      // 32-bit products plus growth over 32 taps
    localparam int out_shift = 16;  // bank 0 gives unity DC gain

    // axis select of a coefficient write where none means no write
    typedef enum logic [1:0] {
        axis_none,
        axis_x,
        axis_y,
        axis_z
    } axis_t;

    typedef struct packed {
        logic signed [sample_w-1:0] x;
        logic signed [sample_w-1:0] y;
        logic signed [sample_w-1:0] z;
    } axis_triple_t;

    typedef struct packed {
        logic [bank_w-1:0] x;
        logic [bank_w-1:0] y;
        logic [bank_w-1:0] z;
    } bank_sel_t;

    typedef struct packed {
        logic en;
        axis_t axis;
        logic [bank_w-1:0] bank;
        logic [tap_idx_w-1:0] index;
        logic [sample_w-1:0] value;
    } coeff_update_t;

endpackage

/* hw/acq_sequencer.sv */
`timescale 1ns/10ps

module acq_sequencer #(
    parameter int sample_div = 500000
) (
    input  logic sys_clk,
    input  logic reset,
    input  logic sample_valid,
    input  logic done,
    output logic acq_req,
    output logic shift_en,
    output logic start,
    output logic available,
    output logic data_irq
);

    localparam int timer_w = $clog2(sample_div);

    typedef enum logic [1:0] {
        st_idle,
        st_wait_sample,
        st_filtering
    } state_t;

    state_t state;
    logic [timer_w-1:0] timer;
    logic timer_wrap;
    logic available_q;

    assign timer_wrap = (timer == timer_w'(sample_div - 1));

    // free-running interval timer
    always_ff @(posedge sys_clk) begin
        if (reset || timer_wrap) begin
            timer <= '0;
        end else begin
            timer <= timer + 1'b1;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            state <= st_idle;
            acq_req <= 1'b0;
            shift_en <= 1'b0;
            start <= 1'b0;
            available <= 1'b1;
        end else begin
            acq_req <= 1'b0;
            shift_en <= 1'b0;
            start <= 1'b0;
            case (state)
                st_idle: begin
                    if (timer_wrap) begin    // wraps while busy are skipped
                        acq_req <= 1'b1;
                        available <= 1'b0;
                        state <= st_wait_sample;
                    end
                end
                st_wait_sample: begin
                    if (sample_valid) begin
                        shift_en <= 1'b1;
                        start <= 1'b1;
                        state <= st_filtering;
                    end
                end
                st_filtering: begin
                    if (done) begin
                        available <= 1'b1;
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // rising edge of available
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            available_q <= 1'b1;
        end else begin
            available_q <= available;
        end
    end

    assign data_irq = available && !available_q;

    // the engine only reports completion of a run we launched
    assert property (@(posedge sys_clk) disable iff (reset)
        done |-> state == st_filtering);

endmodule

/* hw/coeff_bank_store.sv */
`timescale 1ns/10ps

module coeff_bank_store (
    input  logic sys_clk,
    input  logic reset,
    input  accel_fir_pkg::coeff_update_t coeff_update,
    input  accel_fir_pkg::bank_sel_t bank_sel,
    input  logic [accel_fir_pkg::tap_idx_w-1:0] tap_idx,
    output accel_fir_pkg::axis_triple_t tap_coeffs
);

    `include "coeff_lowpass.svh"

    // indexed [axis][bank][tap] with x in axis slot 0
    logic [accel_fir_pkg::sample_w-1:0]
        coeffs [3][accel_fir_pkg::num_banks][accel_fir_pkg::num_taps];

    logic [1:0] axis_slot;
    logic write_en;

    assign axis_slot = coeff_update.axis - 2'd1;
    assign write_en = coeff_update.en && (coeff_update.axis != accel_fir_pkg::axis_none);

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            for (int a = 0; a < 3; a++) begin
                for (int b = 0; b < accel_fir_pkg::num_banks; b++) begin
                    for (int t = 0; t < accel_fir_pkg::num_taps; t++) begin
                        case (b)
                            0: coeffs[a][b][t] <= 16'h0800;   // flat unity gain
                            1: coeffs[a][b][t] <= 16'h0400;   // flat half gain
                            2: coeffs[a][b][t] <= lowpass_coeffs[t];
                            default: coeffs[a][b][t] <= '0;
                        endcase
                    end
                end
            end
        end else if (write_en) begin
            coeffs[axis_slot][coeff_update.bank][coeff_update.index] <= coeff_update.value;
        end
    end

    // one tap of the selected bank per axis
    always_comb begin
        tap_coeffs.x = coeffs[0][bank_sel.x][tap_idx];
        tap_coeffs.y = coeffs[1][bank_sel.y][tap_idx];
        tap_coeffs.z = coeffs[2][bank_sel.z][tap_idx];
    end

    for (genvar a = 0; a < 3; a++) begin : g_none_chk
        // a write aimed at no axis must not disturb any bank
        assert property (@(posedge sys_clk) disable iff (reset)
            coeff_update.en && coeff_update.axis == accel_fir_pkg::axis_none |=>
            coeffs[a][$past(coeff_update.bank)][$past(coeff_update.index)] ==
                $past(coeffs[a][coeff_update.bank][coeff_update.index]));
    end

endmodule

/* hw/tap_delay_line.sv */
`timescale 1ns/10ps

module tap_delay_line (
    input  logic sys_clk,
    input  logic reset,
    input  logic shift_en,
    input  accel_fir_pkg::axis_triple_t sample,
    input  logic [accel_fir_pkg::tap_idx_w-1:0] tap_idx,
    output accel_fir_pkg::axis_triple_t tap_samples
);

    accel_fir_pkg::axis_triple_t sample_q;
    accel_fir_pkg::axis_triple_t history [accel_fir_pkg::num_taps];

    // sample is only valid with the strobe and shift_en comes a cycle later
    always_ff @(posedge sys_clk) begin
        sample_q <= sample;
    end

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            for (int i = 0; i < accel_fir_pkg::num_taps; i++) begin
                history[i] <= '0;
            end
        end else if (shift_en) begin
            history[0] <= sample_q;   // newest at tap 0
            for (int i = 1; i < accel_fir_pkg::num_taps; i++) begin
                history[i] <= history[i-1];
            end
        end
    end

    assign tap_samples = history[tap_idx];

endmodule

/* hw/fir_mac_engine.sv */
`timescale 1ns/10ps

module fir_mac_engine (
    input  logic sys_clk,
    input  logic reset,
    input  logic start,
    input  accel_fir_pkg::axis_triple_t tap_samples,
    input  accel_fir_pkg::axis_triple_t tap_coeffs,
    output logic [accel_fir_pkg::tap_idx_w-1:0] tap_idx,
    output logic done,
    output accel_fir_pkg::axis_triple_t filtered
);

    localparam int top_w = accel_fir_pkg::acc_w - accel_fir_pkg::out_shift
                           - accel_fir_pkg::sample_w + 1;
    localparam int msb = accel_fir_pkg::out_shift + accel_fir_pkg::sample_w - 1;

    logic run;
    logic last_tap;
    logic signed [accel_fir_pkg::acc_w-1:0] acc_x;
    logic signed [accel_fir_pkg::acc_w-1:0] acc_y;
    logic signed [accel_fir_pkg::acc_w-1:0] acc_z;
    logic signed [accel_fir_pkg::acc_w-1:0] next_x;
    logic signed [accel_fir_pkg::acc_w-1:0] next_y;
    logic signed [accel_fir_pkg::acc_w-1:0] next_z;

    // arithmetic shift by out_shift and clamp to the signed sample range
    function automatic logic signed [accel_fir_pkg::sample_w-1:0] scale_sat(
        input logic signed [accel_fir_pkg::acc_w-1:0] a
    );
        logic [top_w-1:0] top;
        top = a[accel_fir_pkg::acc_w-1:msb];
        if (top == '0 || top == '1) begin
            scale_sat = a[msb:accel_fir_pkg::out_shift];
        end else if (a[accel_fir_pkg::acc_w-1]) begin
            scale_sat = {1'b1, {(accel_fir_pkg::sample_w-1){1'b0}}};
        end else begin
            scale_sat = {1'b0, {(accel_fir_pkg::sample_w-1){1'b1}}};
        end
    endfunction

    // operands sign-extend to acc_w before the multiply
    assign next_x = acc_x + $signed(tap_samples.x) * $signed(tap_coeffs.x);
    assign next_y = acc_y + $signed(tap_samples.y) * $signed(tap_coeffs.y);
    assign next_z = acc_z + $signed(tap_samples.z) * $signed(tap_coeffs.z);

    assign last_tap = (tap_idx == accel_fir_pkg::tap_idx_w'(accel_fir_pkg::num_taps - 1));

    always_ff @(posedge sys_clk) begin
        if (start) begin
            acc_x <= '0;
            acc_y <= '0;
            acc_z <= '0;
        end else if (run) begin
            acc_x <= next_x;
            acc_y <= next_y;
            acc_z <= next_z;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            run <= 1'b0;
            tap_idx <= '0;
            done <= 1'b0;
            filtered <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                run <= 1'b1;
                tap_idx <= '0;
            end else if (run) begin
                tap_idx <= tap_idx + 1'b1;   // wraps back to 0 after the last tap
                if (last_tap) begin
                    run <= 1'b0;
                    done <= 1'b1;
                    filtered.x <= scale_sat(next_x);
                    filtered.y <= scale_sat(next_y);
                    filtered.z <= scale_sat(next_z);
                end
            end
        end
    end

    // the sequencer waits for done before the next start
    assert property (@(posedge sys_clk) disable iff (reset)
        start |-> !run);

endmodule

/* hw/accel_fir_top.sv */
`timescale 1ns/10ps

module accel_fir_top #(
    parameter int sample_div = 500000
) (
    input  logic sys_clk,
    input  logic reset,
    input  logic sample_valid,
    input  accel_fir_pkg::axis_triple_t sample,
    input  accel_fir_pkg::coeff_update_t coeff_update,
    input  accel_fir_pkg::bank_sel_t bank_sel,
    output logic acq_req,
    output accel_fir_pkg::axis_triple_t filtered,
    output logic available,
    output logic data_irq
);

    logic shift_en;
    logic start;
    logic done;
    logic [accel_fir_pkg::tap_idx_w-1:0] tap_idx;
    accel_fir_pkg::axis_triple_t tap_samples;
    accel_fir_pkg::axis_triple_t tap_coeffs;

    acq_sequencer #(
        .sample_div(sample_div)
    ) acq_sequencer_i (
        .sys_clk(sys_clk),
        .reset(reset),
        .sample_valid(sample_valid),
        .done(done),
        .acq_req(acq_req),
        .shift_en(shift_en),
        .start(start),
        .available(available),
        .data_irq(data_irq)
    );

    tap_delay_line tap_delay_line_i (
        .sys_clk(sys_clk),
        .reset(reset),
        .shift_en(shift_en),
        .sample(sample),
        .tap_idx(tap_idx),
        .tap_samples(tap_samples)
    );

    coeff_bank_store coeff_bank_store_i (
        .sys_clk(sys_clk),
        .reset(reset),
        .coeff_update(coeff_update),
        .bank_sel(bank_sel),
        .tap_idx(tap_idx),
        .tap_coeffs(tap_coeffs)
    );

    fir_mac_engine fir_mac_engine_i (
        .sys_clk(sys_clk),
        .reset(reset),
        .start(start),
        .tap_samples(tap_samples),
        .tap_coeffs(tap_coeffs),
        .tap_idx(tap_idx),
        .done(done),
        .filtered(filtered)
    );

endmodule

/* bench/accel_fir_ref.svh */
`ifndef ACCEL_FIR_REF_SVH
`define ACCEL_FIR_REF_SVH

// taps 0 to 15 of the symmetric low-pass bank
localparam logic signed [15:0] lp_half [16] = '{
    16'hFFFE, 16'hFFF6, 16'hFFDC, 16'hFF9E,
    16'hFF2A, 16'hFE82, 16'hFDCD, 16'hFD70,
    16'hFE07, 16'h0044, 16'h04AE, 16'h0B4E,
    16'h1380, 16'h1BF4, 16'h22F7, 16'h26F2
};

accel_fir_pkg::axis_triple_t ref_history [accel_fir_pkg::num_taps];   // tap 0 newest
logic signed [15:0] ref_coeffs [3][accel_fir_pkg::num_banks][accel_fir_pkg::num_taps];
int checks = 0;
int mismatches = 0;
int other_errors = 0;

function automatic void reset_reference();
    for (int t = 0; t < accel_fir_pkg::num_taps; t++) begin
        ref_history[t] = '0;
        for (int a = 0; a < 3; a++) begin
            ref_coeffs[a][0][t] = 16'sh0800;
            ref_coeffs[a][1][t] = 16'sh0400;
            ref_coeffs[a][2][t] = lp_half[t < 16 ? t : 31 - t];
            ref_coeffs[a][3][t] = '0;
        end
    end
endfunction

function automatic void push_history(input accel_fir_pkg::axis_triple_t s);
    for (int t = accel_fir_pkg::num_taps - 1; t > 0; t--) begin
        ref_history[t] = ref_history[t-1];
    end
    ref_history[0] = s;
endfunction

// history times coefficient summed, floor shifted by 16 and clamped to 16 bits
function automatic logic signed [15:0] filter_axis(input int axis, input int bank);
    longint sum;
    logic signed [15:0] h;
    sum = 0;
    for (int t = 0; t < accel_fir_pkg::num_taps; t++) begin
        case (axis)
            0: h = ref_history[t].x;
            1: h = ref_history[t].y;
            default: h = ref_history[t].z;
        endcase
        sum += longint'(h) * longint'(ref_coeffs[axis][bank][t]);
    end
    sum = sum >>> 16;
    if (sum > 32767) begin
        return 16'h7FFF;
    end else if (sum < -32768) begin
        return 16'h8000;
    end
    return 16'(sum);
endfunction

function automatic accel_fir_pkg::axis_triple_t expected_filtered(
    input accel_fir_pkg::bank_sel_t sel
);
    accel_fir_pkg::axis_triple_t r;
    r.x = filter_axis(0, sel.x);
    r.y = filter_axis(1, sel.y);
    r.z = filter_axis(2, sel.z);
    return r;
endfunction

task automatic check_value(input string name, input logic signed [63:0] expected,
                           input logic signed [63:0] actual);
    checks++;
    if (expected !== actual) begin
        mismatches++;
        $display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
    end
endtask

`endif

/* bench/accel_fir_tb.sv */
`timescale 1ns/10ps

module accel_fir_tb;

    localparam int sample_div = 64;
    localparam int total_acqs = 150;
    localparam int timeout_cycles = 2 * total_acqs * sample_div + 800;

    logic sys_clk = 1'b0;
    logic reset;
    logic sample_valid;
    accel_fir_pkg::axis_triple_t sample;
    accel_fir_pkg::coeff_update_t coeff_update;
    accel_fir_pkg::bank_sel_t bank_sel;
    logic acq_req;
    accel_fir_pkg::axis_triple_t filtered;
    logic available;
    logic data_irq;

    int cycle_count = 0;
    int results = 0;
    int valid_count = 0;
    int last_req_cycle = -1;
    logic in_flight = 1'b0;
    string test_name = "reset";
    accel_fir_pkg::axis_triple_t expect_val;

    `include "accel_fir_ref.svh"

    accel_fir_top #(
        .sample_div(sample_div)
    ) accel_fir_top_i (
        .sys_clk(sys_clk),
        .reset(reset),
        .sample_valid(sample_valid),
        .sample(sample),
        .coeff_update(coeff_update),
        .bank_sel(bank_sel),
        .acq_req(acq_req),
        .filtered(filtered),
        .available(available),
        .data_irq(data_irq)
    );

    always #4 sys_clk = ~sys_clk;

    always @(posedge sys_clk) cycle_count <= cycle_count + 1;

    task automatic finish_run();
        $display("checks %0d, mismatches %0d, other errors %0d",
                 checks, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    // sensor side answers one request after a random delay
    task automatic acquire(input accel_fir_pkg::axis_triple_t value);
        int seen;
        seen = results;
        @(posedge sys_clk);
        while (!acq_req) @(posedge sys_clk);
        repeat ($urandom_range(1, 8)) @(posedge sys_clk);
        sample_valid <= 1'b1;
        sample <= value;
        push_history(value);
        @(posedge sys_clk);
        sample_valid <= 1'b0;
        wait (results != seen);   // result checked by the comparator
    endtask

    task automatic write_coeff(input accel_fir_pkg::axis_t axis, input int bank,
                               input int index, input logic [15:0] value);
        @(posedge sys_clk);
        coeff_update <= '{en: 1'b1, axis: axis, bank: 2'(bank), index: 5'(index), value: value};
        if (axis != accel_fir_pkg::axis_none) begin
            ref_coeffs[int'(axis) - 1][bank][index] = value;
        end
    endtask

    function automatic accel_fir_pkg::axis_triple_t random_triple();
        accel_fir_pkg::axis_triple_t r;
        r.x = 16'($urandom());
        r.y = 16'($urandom());
        r.z = 16'($urandom());
        return r;
    endfunction

    // full scale on x with signs lined up with the low-pass taps
    function automatic accel_fir_pkg::axis_triple_t sat_triple(input int k, input logic high);
        accel_fir_pkg::axis_triple_t r;
        r = random_triple();
        r.x = ((ref_coeffs[0][2][k] >= 0) == high) ? 16'h7FFF : 16'h8000;
        return r;
    endfunction

    // comparator
    always @(posedge sys_clk) begin
        if (!reset && data_irq) begin
            expect_val = expected_filtered(bank_sel);
            check_value({test_name, " x"}, $signed(expect_val.x), $signed(filtered.x));
            check_value({test_name, " y"}, $signed(expect_val.y), $signed(filtered.y));
            check_value({test_name, " z"}, $signed(expect_val.z), $signed(filtered.z));
            results++;
        end
    end

    // request cadence and busy flag
    always @(posedge sys_clk) begin
        if (!reset) begin
            if (sample_valid) valid_count++;
            if (acq_req) begin
                if (last_req_cycle >= 0) begin
                    check_value("acq_req spacing", 0, (cycle_count - last_req_cycle) % 64);
                end
                last_req_cycle = cycle_count;
                in_flight = 1'b1;
            end
            if (data_irq) begin
                check_value("irq per sample", 1, valid_count);
                valid_count = 0;
                in_flight = 1'b0;
            end else if (in_flight) begin
                check_value("available while busy", 0, available);
            end
        end
    end

    initial begin
        wait (cycle_count >= timeout_cycles);
        other_errors++;
        $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
        finish_run();
    end

    initial begin
        accel_fir_pkg::axis_triple_t const_s;
        reset = 1'b1;
        sample_valid = 1'b0;
        sample = '0;
        coeff_update = '0;
        bank_sel = '0;
        void'($urandom(89089));
        reset_reference();
        repeat (3) @(posedge sys_clk);
        reset <= 1'b0;

        repeat (40) begin   // well before the first timer wrap
            @(posedge sys_clk);
            check_value("reset available", 1, available);
            check_value("reset acq_req", 0, acq_req);
            check_value("reset data_irq", 0, data_irq);
            check_value("reset filtered", 0, filtered);
        end

        test_name = "bank0 constant";
        const_s = '{x: 16'sd1000, y: -16'sd2000, z: 16'sd12345};
        repeat (40) acquire(const_s);
        check_value("bank0 settle x", 1000, $signed(filtered.x));
        check_value("bank0 settle y", -2000, $signed(filtered.y));
        check_value("bank0 settle z", 12345, $signed(filtered.z));

        test_name = "mixed banks";
        @(posedge sys_clk);
        bank_sel <= '{x: 2'd2, y: 2'd1, z: 2'd3};
        repeat (20) acquire(random_triple());
        for (int k = 0; k < 32; k++) acquire(sat_triple(k, 1'b1));
        check_value("lowpass saturate high", 32767, $signed(filtered.x));
        for (int k = 0; k < 32; k++) acquire(sat_triple(k, 1'b0));
        check_value("lowpass saturate low", -32768, $signed(filtered.x));

        test_name = "coeff update";
        write_coeff(accel_fir_pkg::axis_y, 1, 0, 16'h7FFF);
        write_coeff(accel_fir_pkg::axis_y, 1, 5, 16'h8000);
        write_coeff(accel_fir_pkg::axis_none, 1, 3, 16'hDEAD);   // must be dropped
        write_coeff(accel_fir_pkg::axis_y, 1, 17, 16'hF000);
        write_coeff(accel_fir_pkg::axis_y, 1, 31, 16'h1234);
        @(posedge sys_clk);
        coeff_update <= '0;
        repeat (26) acquire(random_triple());

        finish_run();
    end

endmodule

/* list.f */
+incdir+hw
+incdir+bench
hw/accel_fir_pkg.sv
hw/acq_sequencer.sv
hw/coeff_bank_store.sv
hw/tap_delay_line.sv
hw/fir_mac_engine.sv
hw/accel_fir_top.sv
bench/accel_fir_tb.sv

/* Bender.yml */
package:
  name: accel_fir

sources:
  - include_dirs:
      - hw
    files:
      - hw/accel_fir_pkg.sv
      - hw/acq_sequencer.sv
      - hw/coeff_bank_store.sv
      - hw/tap_delay_line.sv
      - hw/fir_mac_engine.sv
      - hw/accel_fir_top.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/accel_fir_tb.sv
